// File: common/asym_fifo_defines.svh
// size constants for the byte-in, word-out FIFO
// include wherever a width, depth or lane count is needed
`ifndef ASYM_FIFO_DEFINES_SVH
`define ASYM_FIFO_DEFINES_SVH

// push side width in bits
`define ASYM_FIFO_W_DATA_W 8

// pop side width in bits
`define ASYM_FIFO_R_DATA_W 32

// address width in bytes, 64 byte storage
`define ASYM_FIFO_ADDR_W 6

// byte lanes per popped word
`define ASYM_FIFO_RATIO 4

// 0 puts the first pushed byte in bits 7:0
`define ASYM_FIFO_BIG_ENDIAN 0

// row address of the lane RAM
`define ASYM_FIFO_WIDE_ADDR_W 4

`endif

// File: common/asym_fifo_pkg.sv
// shared types of the asymmetric FIFO
// vector types for data, pointers and level, plus the RAM port bundles
`default_nettype none

`include "asym_fifo_defines.svh"

package asym_fifo_pkg;

   typedef logic [`ASYM_FIFO_W_DATA_W-1:0]    narrow_word_t;
   typedef logic [`ASYM_FIFO_R_DATA_W-1:0]    wide_word_t;
   typedef logic [`ASYM_FIFO_ADDR_W-1:0]      narrow_addr_t;
   typedef logic [`ASYM_FIFO_WIDE_ADDR_W-1:0] wide_addr_t;
   // one extra bit so that a full FIFO can be told from an empty one
   typedef logic [`ASYM_FIFO_ADDR_W:0]        level_t;
   typedef logic [`ASYM_FIFO_RATIO-1:0]       lane_en_t;

   // write request towards the lane RAM
   typedef struct packed {
      lane_en_t   en;
      wide_addr_t addr;
      wide_word_t data;
   } mem_wr_t;

   // read request towards the lane RAM
   typedef struct packed {
      lane_en_t   en;
      wide_addr_t addr;
   } mem_rd_t;

endpackage

`default_nettype wire

// File: design/asym_fifo/asym_converter.sv
// maps a narrow and a wide port onto the byte-lane RAM
// read data is registered, so the read port keeps the last word read
`timescale 1ns/10ps
`default_nettype none

module asym_converter #(
   parameter int W_DATA_W   = 8,
   parameter int R_DATA_W   = 32,
   // address width on the narrow side
   parameter int ADDR_W     = 6,
   parameter int BIG_ENDIAN = 0,
   localparam int MAX_W     = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W,
   localparam int MIN_W     = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W,
   localparam int R         = MAX_W / MIN_W,
   localparam int SEL_W     = $clog2(R),
   localparam int W_ADDR_W  = (W_DATA_W == MAX_W) ? ADDR_W - SEL_W : ADDR_W,
   localparam int R_ADDR_W  = (R_DATA_W == MAX_W) ? ADDR_W - SEL_W : ADDR_W
) (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic                       w_en_i,
   input  logic [W_ADDR_W-1:0]        w_addr_i,
   input  logic [W_DATA_W-1:0]        w_data_i,
   input  logic                       r_en_i,
   input  logic [R_ADDR_W-1:0]        r_addr_i,
   output logic [R_DATA_W-1:0]        r_data_o,
   output asym_fifo_pkg::mem_wr_t     mem_wr_o,
   output asym_fifo_pkg::mem_rd_t     mem_rd_o,
   input  asym_fifo_pkg::wide_word_t  mem_r_data_i
);

   asym_fifo_pkg::lane_en_t   wr_lane;
   asym_fifo_pkg::wide_addr_t wr_row;
   asym_fifo_pkg::wide_word_t wr_data;
   asym_fifo_pkg::lane_en_t   rd_lane_d;
   asym_fifo_pkg::wide_addr_t rd_row_d;
   asym_fifo_pkg::lane_en_t   rd_lane_q;
   asym_fifo_pkg::wide_addr_t rd_row_q;
   logic                      r_valid_q;
   asym_fifo_pkg::wide_word_t r_data_q;
   asym_fifo_pkg::wide_word_t r_data_int;

   assign mem_wr_o = '{en: wr_lane, addr: wr_row, data: wr_data};
   // read request goes out one cycle after the strobe
   assign mem_rd_o = '{en: rd_lane_q, addr: rd_row_q};

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_lane_q <= '0;
         r_valid_q <= 1'b0;
         r_data_q  <= '0;
      end else begin
         rd_lane_q <= rd_lane_d;
         // RAM output is fresh in the cycle after the request
         r_valid_q <= |rd_lane_q;
         if (r_valid_q) begin
            r_data_q <= mem_r_data_i;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      rd_row_q <= rd_row_d;
   end

   // fresh RAM data in the valid cycle, held copy afterwards
   always_comb begin
      if (r_valid_q) begin
         r_data_int = mem_r_data_i;
      end else begin
         r_data_int = r_data_q;
      end
   end

   if (W_DATA_W < R_DATA_W) begin : g_read_wider
      logic [SEL_W-1:0] w_sel;

      // one lane per narrow write, selected by the low address bits
      assign w_sel     = w_addr_i[SEL_W-1:0];
      assign wr_lane   = {{(R - 1){1'b0}}, w_en_i} << w_sel;
      assign wr_row    = w_addr_i[W_ADDR_W-1:SEL_W];
      assign wr_data   = {{(MAX_W - W_DATA_W){1'b0}}, w_data_i} << (w_sel * W_DATA_W);
      assign rd_lane_d = {R{r_en_i}};
      assign rd_row_d  = r_addr_i;

      if (BIG_ENDIAN != 0) begin : g_big_endian
         for (genvar i = 0; i < R; i++) begin : g_lane
            assign r_data_o[i*W_DATA_W +: W_DATA_W] = r_data_int[(R-1-i)*W_DATA_W +: W_DATA_W];
         end
      end else begin : g_little_endian
         assign r_data_o = r_data_int;
      end

   end else if (W_DATA_W > R_DATA_W) begin : g_write_wider
      logic [SEL_W-1:0] r_sel;
      logic [SEL_W-1:0] lane_idx;
      logic [SEL_W-1:0] rd_sel_q;
      logic [SEL_W-1:0] out_sel_q;
      logic [MAX_W-1:0] r_shift;

      // a wide write fills every lane of the row
      assign wr_lane = {R{w_en_i}};
      assign wr_row  = w_addr_i;
      assign wr_data = w_data_i;

      assign r_sel     = r_addr_i[SEL_W-1:0];
      assign lane_idx  = (BIG_ENDIAN != 0) ? SEL_W'(R - 1) - r_sel : r_sel;
      assign rd_lane_d = {{(R - 1){1'b0}}, r_en_i} << lane_idx;
      assign rd_row_d  = r_addr_i[R_ADDR_W-1:SEL_W];

      // lane select follows the request down the read pipe
      always_ff @(posedge clk_i) begin
         rd_sel_q <= lane_idx;
      end

      always_ff @(posedge clk_i) begin
         if (!rst_n_i) begin
            out_sel_q <= '0;
         end else if (|rd_lane_q) begin
            out_sel_q <= rd_sel_q;
         end
      end

      assign r_shift  = r_data_int >> (out_sel_q * R_DATA_W);
      assign r_data_o = r_shift[R_DATA_W-1:0];

   end else begin : g_same_width
      $error("asym_converter needs different write and read widths");
   end

endmodule

`default_nettype wire

// File: design/asym_fifo/banked_ram.sv
// dual-port RAM built from byte-wide lanes
// every lane has its own write and read enable, reads take one cycle
`timescale 1ns/10ps
`default_nettype none

module banked_ram #(
   parameter int LANES  = 4,
   // row address width
   parameter int ADDR_W = 4
) (
   input  logic                      clk_i,
   input  asym_fifo_pkg::mem_wr_t    mem_wr_i,
   input  asym_fifo_pkg::mem_rd_t    mem_rd_i,
   output asym_fifo_pkg::wide_word_t r_data_o
);

   localparam int LANE_W = $bits(asym_fifo_pkg::wide_word_t) / LANES;
   localparam int DEPTH  = 2 ** ADDR_W;

   for (genvar l = 0; l < LANES; l++) begin : g_lane
      logic [LANE_W-1:0] mem_q [DEPTH];
      logic [LANE_W-1:0] rd_q;

      always_ff @(posedge clk_i) begin
         if (mem_wr_i.en[l]) begin
            mem_q[mem_wr_i.addr] <= mem_wr_i.data[l*LANE_W +: LANE_W];
         end
         // old contents on a same-row write, lane holds when not read
         if (mem_rd_i.en[l]) begin
            rd_q <= mem_q[mem_rd_i.addr];
         end
      end

      assign r_data_o[l*LANE_W +: LANE_W] = rd_q;
   end

endmodule

`default_nettype wire

// File: design/asym_fifo/fifo_ctrl.sv
// pointer and level bookkeeping of the asymmetric FIFO
// gates push and pop with full and empty and drives the RAM side strobes
`timescale 1ns/10ps
`default_nettype none

`include "asym_fifo_defines.svh"

module fifo_ctrl (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   input  logic                        push_i,
   input  logic                        pop_i,
   output logic                        w_en_o,
   output logic                        r_en_o,
   output asym_fifo_pkg::narrow_addr_t w_addr_o,
   output asym_fifo_pkg::narrow_addr_t r_addr_o,
   output logic                        full_o,
   output logic                        empty_o,
   output asym_fifo_pkg::level_t       level_o
);

   // storage size in bytes
   localparam int DEPTH = 2 ** `ASYM_FIFO_ADDR_W;
   // bytes taken by one pop
   localparam int RATIO = `ASYM_FIFO_RATIO;

   asym_fifo_pkg::narrow_addr_t w_ptr_q;
   asym_fifo_pkg::narrow_addr_t r_ptr_q;
   asym_fifo_pkg::level_t       level_q;
   asym_fifo_pkg::level_t       level_d;

   // flags come straight from the registered level
   assign full_o  = (level_q == asym_fifo_pkg::level_t'(DEPTH));
   // a pop needs a whole word stored
   assign empty_o = (level_q < asym_fifo_pkg::level_t'(RATIO));

   // accepted strobes, a request against a flag is dropped
   assign w_en_o = push_i & ~full_o;
   assign r_en_o = pop_i & ~empty_o;

   // push and pop may land in the same cycle
   always_comb begin
      level_d = level_q;
      if (w_en_o) begin
         level_d = level_d + asym_fifo_pkg::level_t'(1);
      end
      if (r_en_o) begin
         level_d = level_d - asym_fifo_pkg::level_t'(RATIO);
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
         level_q <= '0;
      end else begin
         // both pointers wrap at the end of storage
         if (w_en_o) begin
            w_ptr_q <= w_ptr_q + asym_fifo_pkg::narrow_addr_t'(1);
         end
         // read pointer moves a full word, low bits stay zero
         if (r_en_o) begin
            r_ptr_q <= r_ptr_q + asym_fifo_pkg::narrow_addr_t'(RATIO);
         end
         level_q <= level_d;
      end
   end

   assign w_addr_o = w_ptr_q;
   assign r_addr_o = r_ptr_q;
   assign level_o  = level_q;

endmodule

`default_nettype wire

// File: design/asym_fifo/asym_fifo.sv
// top of the FIFO with a byte push port and a word pop port
// popped word appears one cycle after the pop is taken and holds until the next
`timescale 1ns/10ps
`default_nettype none

`include "asym_fifo_defines.svh"

module asym_fifo (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   input  logic                        push_i,
   input  asym_fifo_pkg::narrow_word_t w_data_i,
   input  logic                        pop_i,
   output asym_fifo_pkg::wide_word_t   r_data_o,
   output logic                        full_o,
   output logic                        empty_o,
   output asym_fifo_pkg::level_t       level_o
);

   logic                        w_en;
   logic                        r_en;
   asym_fifo_pkg::narrow_addr_t w_addr;
   asym_fifo_pkg::narrow_addr_t r_addr;
   asym_fifo_pkg::mem_wr_t      mem_wr;
   asym_fifo_pkg::mem_rd_t      mem_rd;
   asym_fifo_pkg::wide_word_t   mem_r_data;

   fifo_ctrl i_fifo_ctrl (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (push_i),
      .pop_i   (pop_i),
      .w_en_o  (w_en),
      .r_en_o  (r_en),
      .w_addr_o(w_addr),
      .r_addr_o(r_addr),
      .full_o  (full_o),
      .empty_o (empty_o),
      .level_o (level_o)
   );

   // read side takes the row part of the byte pointer
   asym_converter #(
      .W_DATA_W  (`ASYM_FIFO_W_DATA_W),
      .R_DATA_W  (`ASYM_FIFO_R_DATA_W),
      .ADDR_W    (`ASYM_FIFO_ADDR_W),
      .BIG_ENDIAN(`ASYM_FIFO_BIG_ENDIAN)
   ) i_asym_converter (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .w_en_i      (w_en),
      .w_addr_i    (w_addr),
      .w_data_i    (w_data_i),
      .r_en_i      (r_en),
      .r_addr_i    (r_addr[`ASYM_FIFO_ADDR_W-1:`ASYM_FIFO_ADDR_W-`ASYM_FIFO_WIDE_ADDR_W]),
      .r_data_o    (r_data_o),
      .mem_wr_o    (mem_wr),
      .mem_rd_o    (mem_rd),
      .mem_r_data_i(mem_r_data)
   );

   banked_ram #(
      .LANES (`ASYM_FIFO_RATIO),
      .ADDR_W(`ASYM_FIFO_WIDE_ADDR_W)
   ) i_banked_ram (
      .clk_i   (clk_i),
      .mem_wr_i(mem_wr),
      .mem_rd_i(mem_rd),
      .r_data_o(mem_r_data)
   );

endmodule

`default_nettype wire

// File: dv/asym_fifo_properties.sv
// concurrent checks on the flags and accepted strobes of the FIFO controller
// attached to every fifo_ctrl instance through the bind at the end
`timescale 1ns/10ps
`default_nettype none

`include "asym_fifo_defines.svh"

module asym_fifo_properties (
   input logic                  clk_i,
   input logic                  rst_n_i,
   input logic                  w_en_i,
   input logic                  r_en_i,
   input logic                  full_i,
   input logic                  empty_i,
   input asym_fifo_pkg::level_t level_i
);

   localparam int DEPTH = 2 ** `ASYM_FIFO_ADDR_W;

   flags_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(full_i && empty_i))
      else $error("full and empty are high together");

   level_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      level_i <= asym_fifo_pkg::level_t'(DEPTH))
      else $error("level above storage size");

   no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      w_en_i |-> !full_i)
      else $error("write strobe while full");

   no_read_when_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_en_i |-> !empty_i)
      else $error("read strobe while empty");

endmodule

bind fifo_ctrl asym_fifo_properties i_asym_fifo_properties (
   .clk_i  (clk_i),
   .rst_n_i(rst_n_i),
   .w_en_i (w_en_o),
   .r_en_i (r_en_o),
   .full_i (full_o),
   .empty_i(empty_o),
   .level_i(level_o)
);

`default_nettype wire

// File: dv/asym_fifo_tb.sv
// testbench for the byte-in, word-out FIFO
// applies a table of push/pop runs and compares against a byte queue model
`timescale 1ns/10ps
`default_nettype none

`include "asym_fifo_defines.svh"

module asym_fifo_tb;

   localparam int DEPTH      = 2 ** `ASYM_FIFO_ADDR_W;
   localparam int RATIO      = `ASYM_FIFO_RATIO;
   localparam int BYTE_W     = `ASYM_FIFO_W_DATA_W;
   localparam int N_STEPS    = 19;
   localparam int WAIT_LIMIT = 100;

   // one table row, a run of identical cycles, rnd picks push and pop at random
   typedef struct packed {
      logic        push;
      logic        pop;
      logic        rnd;
      logic [15:0] count;
   } step_t;

   logic                        clk_i = 1'b0;
   logic                        rst_n_i;
   logic                        push_i;
   logic                        pop_i;
   asym_fifo_pkg::narrow_word_t w_data_i;
   asym_fifo_pkg::wide_word_t   r_data_o;
   logic                        full_o;
   logic                        empty_o;
   asym_fifo_pkg::level_t       level_o;

   asym_fifo_pkg::narrow_word_t model_q [$];
   asym_fifo_pkg::wide_word_t   exp_rdata;
   asym_fifo_pkg::wide_word_t   pend_word;
   logic                        pend_valid;
   logic [31:0]                 rng_state;
   int                          error_count;
   int                          check_count;

   step_t steps [N_STEPS] = '{
      // single word round trip, then hold while idle
      '{1, 0, 0, 4}, '{0, 1, 0, 1}, '{0, 0, 0, 4},
      // partial word, pops are ignored
      '{1, 0, 0, 3}, '{0, 1, 0, 3}, '{0, 0, 0, 2},
      '{1, 0, 0, 1}, '{0, 1, 0, 1}, '{0, 0, 0, 3},
      // overfill, push and pop at full, then drain every word
      '{1, 0, 0, 70}, '{0, 0, 0, 2}, '{1, 1, 0, 2}, '{0, 1, 0, 20},
      // simultaneous push and pop
      '{1, 0, 0, 12}, '{1, 1, 0, 6}, '{0, 1, 0, 4},
      // long random mix wraps both pointers
      '{1, 0, 0, 30}, '{0, 0, 1, 600}, '{0, 0, 0, 5}
   };

   asym_fifo i_asym_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (push_i),
      .w_data_i(w_data_i),
      .pop_i   (pop_i),
      .r_data_o(r_data_o),
      .full_o  (full_o),
      .empty_o (empty_o),
      .level_o (level_o)
   );

   always #50 clk_i = ~clk_i;

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_outputs();
      compare_value("level_o", 32'(level_o), 32'(model_q.size()));
      compare_value("full_o", 32'(full_o), 32'(model_q.size() == DEPTH));
      compare_value("empty_o", 32'(empty_o), 32'(model_q.size() < RATIO));
      compare_value("r_data_o", r_data_o, exp_rdata);
   endtask

   // drives one cycle 5 ns after the edge and checks 5 ns after the next edge
   task automatic run_cycle(input logic push, input logic pop);
      logic                        push_ok;
      logic                        pop_ok;
      asym_fifo_pkg::narrow_word_t data;
      asym_fifo_pkg::wide_word_t   word;
      rng_state = lcg_next(rng_state);
      data      = rng_state[23:16];
      push_i    = push;
      pop_i     = pop;
      w_data_i  = data;
      push_ok   = push && (model_q.size() < DEPTH);
      pop_ok    = pop && (model_q.size() >= RATIO);
      word      = '0;
      if (pop_ok) begin
         // oldest byte lands in the low lane
         for (int i = 0; i < RATIO; i++) begin
            word[i*BYTE_W +: BYTE_W] = model_q.pop_front();
         end
      end
      if (push_ok) begin
         model_q.push_back(data);
      end
      @(posedge clk_i);
      #5;
      // popped word shows up one edge after the pop
      if (pend_valid) begin
         exp_rdata = pend_word;
      end
      pend_valid = pop_ok;
      pend_word  = word;
      check_outputs();
   endtask

   task automatic wait_reset_flags();
      int cycles;
      cycles = 0;
      while (empty_o !== 1'b1 && cycles < WAIT_LIMIT) begin
         @(posedge clk_i);
         #5;
         cycles++;
      end
      if (empty_o !== 1'b1) begin
         error_count++;
         $display("timeout: empty flag never came up after reset");
      end
   endtask

   task automatic drain_until_empty();
      int cycles;
      cycles = 0;
      while (empty_o !== 1'b1 && cycles < WAIT_LIMIT) begin
         run_cycle(1'b0, 1'b1);
         cycles++;
      end
      if (empty_o !== 1'b1) begin
         error_count++;
         $display("timeout: FIFO still holds a word after %0d pops", WAIT_LIMIT);
      end
   endtask

   initial begin
      rst_n_i     = 1'b0;
      push_i      = 1'b0;
      pop_i       = 1'b0;
      w_data_i    = '0;
      rng_state   = 32'h3ab004cb;
      exp_rdata   = '0;
      pend_word   = '0;
      pend_valid  = 1'b0;
      error_count = 0;
      check_count = 0;
      repeat (10) @(posedge clk_i);
      #5;
      rst_n_i = 1'b1;
      wait_reset_flags();
      check_outputs();
      for (int s = 0; s < N_STEPS; s++) begin
         for (int c = 0; c < int'(steps[s].count); c++) begin
            if (steps[s].rnd) begin
               rng_state = lcg_next(rng_state);
               // pops take a word, so they come about 1 in 8 cycles
               run_cycle(rng_state[16], rng_state[27:25] == 3'd0);
            end else begin
               run_cycle(steps[s].push, steps[s].pop);
            end
         end
      end
      drain_until_empty();
      repeat (3) run_cycle(1'b0, 1'b0);
      $display("checks: %0d errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: asym_fifo.f
+incdir+common
common/asym_fifo_pkg.sv
design/asym_fifo/asym_converter.sv
design/asym_fifo/banked_ram.sv
design/asym_fifo/fifo_ctrl.sv
design/asym_fifo/asym_fifo.sv
dv/asym_fifo_properties.sv
dv/asym_fifo_tb.sv

// File: Bender.yml
package:
  name: asym_fifo

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/asym_fifo_pkg.sv
      - design/asym_fifo/asym_converter.sv
      - design/asym_fifo/banked_ram.sv
      - design/asym_fifo/fifo_ctrl.sv
      - design/asym_fifo/asym_fifo.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/asym_fifo_properties.sv
      - dv/asym_fifo_tb.sv
